// File: common/csma_timing_pkg.sv
// CSMA timing definitions
package csma_timing_pkg;

    typedef logic [11:0] usec_t;     // ifs and wait times in us
    typedef logic [14:0] nav_t;      // nav in us
    typedef logic [12:0] backoff_t;  // backoff countdown in us
    typedef logic [9:0]  slot_cnt_t;
    typedef logic [3:0]  cw_exp_t;

    localparam usec_t       LONGEST_ACK_TIME = 12'd44;
    localparam cw_exp_t     CW_EXP_MAX       = 4'd10;   // cw of 1023 slots
    localparam logic [31:0] LFSR_RESET_VALUE = 32'h1020f0cb;

    typedef enum logic [2:0] {
        bo_idle,
        bo_ch_busy,
        bo_wait_new,      // ifs only
        bo_wait_retrans,  // ifs, then slot backoff
        bo_run,
        bo_suspend,
        bo_wait_for_own
    } backoff_state_e;

    typedef enum logic [1:0] {
        nav_idle,
        nav_wait_duration,
        nav_check_ra,
        nav_update
    } nav_state_e;

endpackage

// File: common/mac_frame_pkg.sv
// 802.11 frame field definitions
package mac_frame_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] duration_t;
    typedef logic [1:0]  fc_type_t;
    typedef logic [3:0]  fc_subtype_t;

    // duration field with this bit set holds an aid or reserved value
    localparam int DUR_NO_NAV_BIT = 15;

    localparam fc_type_t    FC_TYPE_CTRL      = 2'b01;
    localparam fc_subtype_t FC_SUBTYPE_PSPOLL = 4'b1010;

endpackage

// File: common/rx_frame_if.sv
// Receiver frame event bundle
interface rx_frame_if;

    logic                      header_valid_strobe;  // restarts nav decoding
    logic                      header_valid;
    logic                      fc_valid;             // qualifies fc fields and duration
    mac_frame_pkg::fc_type_t    fc_type;
    mac_frame_pkg::fc_subtype_t fc_subtype;
    mac_frame_pkg::duration_t   duration;
    logic                      addr1_valid;
    mac_frame_pkg::mac_addr_t   addr1;
    logic                      fcs_strobe;
    logic                      fcs_valid;

    modport sink (
        input header_valid_strobe,
        input header_valid,
        input fc_valid,
        input fc_type,
        input fc_subtype,
        input duration,
        input addr1_valid,
        input addr1,
        input fcs_strobe,
        input fcs_valid
    );

endinterface

// File: rtl/nav/nav_tracker.sv
// NAV virtual carrier sense
module nav_tracker (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     tsf_pulse_1M,
    rx_frame_if.sink                 frame,
    input  mac_frame_pkg::mac_addr_t self_mac_addr,
    input  logic                     nav_enable,
    input  logic                     ch_idle,
    output logic                     medium_idle
);

    csma_timing_pkg::nav_state_e state;
    csma_timing_pkg::nav_t       nav;
    csma_timing_pkg::nav_t       nav_new;  // duration captured from the frame
    logic                        nav_set;
    logic                        is_pspoll;
    logic                        dur_ok;

    // ps-poll carries an aid in the duration field, not a nav value
    assign is_pspoll = (frame.fc_type == mac_frame_pkg::FC_TYPE_CTRL) &&
                       (frame.fc_subtype == mac_frame_pkg::FC_SUBTYPE_PSPOLL);
    assign dur_ok = frame.fc_valid && !frame.duration[mac_frame_pkg::DUR_NO_NAV_BIT] &&
                    !is_pspoll;

    assign medium_idle = ch_idle && (!nav_enable || nav == '0);

    always_ff @(posedge clk) begin
        if (state == csma_timing_pkg::nav_wait_duration && dur_ok) begin
            nav_new <= frame.duration[14:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= csma_timing_pkg::nav_idle;
            nav     <= '0;
            nav_set <= 1'b0;
        end else begin
            // nav only grows on update, else counts down per us
            if (nav_set) begin
                nav <= (nav_new > nav) ? nav_new : nav;
            end else if (tsf_pulse_1M && nav != '0) begin
                nav <= nav - 1'b1;
            end

            nav_set <= 1'b0;
            if (frame.header_valid_strobe) begin
                // also recovers from a receiver that never strobes fcs
                state <= frame.header_valid ? csma_timing_pkg::nav_wait_duration
                                            : csma_timing_pkg::nav_idle;
            end else begin
                case (state)
                    csma_timing_pkg::nav_wait_duration: begin
                        if (dur_ok) begin
                            state <= csma_timing_pkg::nav_check_ra;
                        end
                    end
                    csma_timing_pkg::nav_check_ra: begin
                        // frames for us never set the nav
                        if (frame.addr1_valid && frame.addr1 != self_mac_addr) begin
                            state <= csma_timing_pkg::nav_update;
                        end
                    end
                    csma_timing_pkg::nav_update: begin
                        if (frame.fcs_strobe && frame.fcs_valid) begin
                            nav_set <= 1'b1;
                            state   <= csma_timing_pkg::nav_idle;
                        end
                    end
                    default: ;  // idle until next header
                endcase
            end
        end
    end

endmodule

// File: rtl/backoff/slot_draw.sv
// Random backoff slot draw
module slot_draw (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       take_new,
    input  csma_timing_pkg::cw_exp_t   cw_exp,
    input  logic [1:0]                 random_seed,
    output csma_timing_pkg::slot_cnt_t num_slot
);

    logic [31:0]                lfsr;
    csma_timing_pkg::cw_exp_t   exp_cap;
    csma_timing_pkg::slot_cnt_t mask;
    csma_timing_pkg::slot_cnt_t seed_mix;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lfsr <= csma_timing_pkg::LFSR_RESET_VALUE;
        end else if (take_new) begin
            lfsr <= {lfsr[30:0], ~^{lfsr[31], lfsr[21], lfsr[1:0]}};  // taps 32,22,2,1
        end
    end

    assign exp_cap = (cw_exp > csma_timing_pkg::CW_EXP_MAX) ? csma_timing_pkg::CW_EXP_MAX
                                                           : cw_exp;
    assign mask = csma_timing_pkg::slot_cnt_t'((11'd1 << exp_cap) - 11'd1);

    // seed perturbs the two low bits, bit 1 only when it is in the window
    assign seed_mix = {8'd0, random_seed[0] & (exp_cap >= 4'd2), random_seed[1]};

    assign num_slot = (lfsr[9:0] ^ seed_mix) & mask;  // exp 0 gives 0

endmodule

// File: rtl/backoff/backoff_fsm.sv
// Interframe wait and random backoff
module backoff_fsm (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       tsf_pulse_1M,
    input  logic                       medium_idle,
    input  logic                       fcs_strobe,
    input  logic                       fcs_valid,
    input  logic                       difs_enable,
    input  logic                       eifs_enable,
    input  csma_timing_pkg::usec_t     slot_time,
    input  csma_timing_pkg::usec_t     sifs_time,
    input  csma_timing_pkg::usec_t     difs_advance,
    input  csma_timing_pkg::usec_t     backoff_advance,
    input  csma_timing_pkg::cw_exp_t   cw_exp_used,
    input  csma_timing_pkg::slot_cnt_t num_slot,
    input  logic                       high_trigger,
    input  logic                       retrans_trigger,
    input  logic                       quit_retrans,
    input  logic                       tx_bb_is_ongoing,
    input  logic                       ack_tx_flag,
    output logic                       take_new,
    output logic                       backoff_done,
    output csma_timing_pkg::slot_cnt_t num_slot_random_log_dl,
    output csma_timing_pkg::cw_exp_t   cw_exp_log_dl
);

    csma_timing_pkg::backoff_state_e state;
    csma_timing_pkg::usec_t          difs_time;
    csma_timing_pkg::usec_t          eifs_time;
    csma_timing_pkg::usec_t          ifs_time;
    csma_timing_pkg::usec_t          ifs_wait;
    csma_timing_pkg::usec_t          resume_wait;
    csma_timing_pkg::usec_t          wait_timer;
    csma_timing_pkg::backoff_t       backoff_timer;
    csma_timing_pkg::backoff_t       backoff_load;
    csma_timing_pkg::slot_cnt_t      slot_log;
    csma_timing_pkg::slot_cnt_t      slot_log_dl1;
    csma_timing_pkg::cw_exp_t        cw_log;
    csma_timing_pkg::cw_exp_t        cw_log_dl1;
    logic                            last_fcs_valid;
    logic                            new_req;

    assign difs_time = difs_enable ? sifs_time + (slot_time << 1) : '0;
    assign eifs_time = eifs_enable ? sifs_time + difs_time + csma_timing_pkg::LONGEST_ACK_TIME
                                   : '0;
    assign ifs_time  = last_fcs_valid ? difs_time : eifs_time;  // eifs after a bad fcs
    assign ifs_wait  = (ifs_time == '0) ? '0 : ifs_time - difs_advance;

    // quit during backoff never waits longer than what is left
    assign resume_wait = (backoff_timer > csma_timing_pkg::backoff_t'(ifs_time)) ? ifs_wait
                       : csma_timing_pkg::usec_t'(backoff_timer);

    assign backoff_load = (num_slot == '0) ? '0
        : csma_timing_pkg::backoff_t'(num_slot) * csma_timing_pkg::backoff_t'(slot_time)
          - csma_timing_pkg::backoff_t'(backoff_advance);

    assign new_req      = high_trigger || quit_retrans;
    assign backoff_done = (state == csma_timing_pkg::bo_wait_for_own);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state                  <= csma_timing_pkg::bo_idle;
            wait_timer             <= '0;
            backoff_timer          <= '0;
            last_fcs_valid         <= 1'b0;
            take_new               <= 1'b0;
            slot_log               <= '0;
            slot_log_dl1           <= '0;
            num_slot_random_log_dl <= '0;
            cw_log                 <= '0;
            cw_log_dl1             <= '0;
            cw_exp_log_dl          <= '0;
        end else begin
            if (fcs_strobe) begin
                last_fcs_valid <= fcs_valid;
            end
            // next draw is ready before the wait reaches 0
            take_new <= (state == csma_timing_pkg::bo_wait_retrans) && tsf_pulse_1M &&
                        (wait_timer == 12'd2);

            slot_log_dl1           <= slot_log;  // two stage delay, holds through a quit
            num_slot_random_log_dl <= slot_log_dl1;
            cw_log_dl1             <= cw_log;
            cw_exp_log_dl          <= cw_log_dl1;

            if (state == csma_timing_pkg::bo_wait_new ||
                state == csma_timing_pkg::bo_wait_retrans) begin
                if (tsf_pulse_1M && wait_timer != '0) begin
                    wait_timer <= wait_timer - 1'b1;
                end
            end

            case (state)
                csma_timing_pkg::bo_idle: begin
                    backoff_timer <= '0;
                    if (new_req) begin
                        slot_log <= '0;
                        cw_log   <= '0;
                    end
                    if (!medium_idle) begin
                        if (new_req || retrans_trigger) begin
                            state      <= csma_timing_pkg::bo_ch_busy;
                            wait_timer <= '0;
                        end
                    end else if (new_req) begin
                        state      <= csma_timing_pkg::bo_wait_new;
                        wait_timer <= ifs_wait;
                    end else if (retrans_trigger) begin
                        state      <= csma_timing_pkg::bo_wait_retrans;
                        wait_timer <= ifs_wait;
                    end
                end
                csma_timing_pkg::bo_ch_busy: begin
                    backoff_timer <= '0;
                    wait_timer    <= medium_idle ? ifs_wait : '0;
                    if (medium_idle) begin
                        state <= csma_timing_pkg::bo_wait_retrans;  // busy medium forces backoff
                    end
                end
                csma_timing_pkg::bo_wait_new: begin
                    slot_log <= '0;
                    cw_log   <= '0;
                    if (!medium_idle) begin
                        state <= csma_timing_pkg::bo_ch_busy;
                    end else if (wait_timer == '0) begin
                        state <= csma_timing_pkg::bo_wait_for_own;
                    end
                end
                csma_timing_pkg::bo_wait_retrans: begin
                    if (!medium_idle) begin
                        state         <= csma_timing_pkg::bo_ch_busy;
                        backoff_timer <= '0;
                    end else if (quit_retrans) begin
                        state <= csma_timing_pkg::bo_wait_new;
                    end else if (wait_timer == '0) begin
                        state         <= csma_timing_pkg::bo_run;
                        backoff_timer <= backoff_load;
                        slot_log      <= num_slot;
                        cw_log        <= cw_exp_used;
                    end
                end
                csma_timing_pkg::bo_run: begin
                    if (!medium_idle) begin
                        state <= (backoff_timer == '0) ? csma_timing_pkg::bo_ch_busy
                                                       : csma_timing_pkg::bo_suspend;
                    end else begin
                        if (tsf_pulse_1M && backoff_timer != '0) begin
                            backoff_timer <= backoff_timer - 1'b1;
                        end
                        if (quit_retrans) begin
                            state      <= csma_timing_pkg::bo_wait_new;
                            wait_timer <= resume_wait;
                        end else if (backoff_timer == '0) begin
                            state <= csma_timing_pkg::bo_wait_for_own;
                        end
                    end
                end
                csma_timing_pkg::bo_suspend: begin
                    if (medium_idle) begin
                        state <= quit_retrans ? csma_timing_pkg::bo_wait_new
                                              : csma_timing_pkg::bo_run;
                        if (quit_retrans) begin
                            wait_timer <= resume_wait;
                        end
                    end else if (quit_retrans) begin
                        state    <= csma_timing_pkg::bo_ch_busy;
                        slot_log <= '0;
                        cw_log   <= '0;
                    end
                end
                csma_timing_pkg::bo_wait_for_own: begin
                    if (tx_bb_is_ongoing) begin
                        // an ack we send must be followed by a fresh ifs
                        state <= ack_tx_flag ? csma_timing_pkg::bo_ch_busy
                                             : csma_timing_pkg::bo_idle;
                    end
                end
                default: state <= csma_timing_pkg::bo_idle;
            endcase
        end
    end

endmodule

// File: rtl/csma_ca.sv
// CSMA/CA access controller top
module csma_ca (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       tsf_pulse_1M,
    input  logic                       pkt_header_valid,
    input  logic                       pkt_header_valid_strobe,
    input  logic                       fc_di_valid,
    input  mac_frame_pkg::fc_type_t    fc_type,
    input  mac_frame_pkg::fc_subtype_t fc_subtype,
    input  mac_frame_pkg::duration_t   duration,
    input  logic                       addr1_valid,
    input  mac_frame_pkg::mac_addr_t   addr1,
    input  mac_frame_pkg::mac_addr_t   self_mac_addr,
    input  logic                       fcs_in_strobe,
    input  logic                       fcs_valid,
    input  logic                       nav_enable,
    input  logic                       ch_idle,
    input  logic                       difs_enable,
    input  logic                       eifs_enable,
    input  csma_timing_pkg::cw_exp_t   cw_exp_used,
    input  csma_timing_pkg::usec_t     slot_time,
    input  csma_timing_pkg::usec_t     sifs_time,
    input  csma_timing_pkg::usec_t     difs_advance,
    input  csma_timing_pkg::usec_t     backoff_advance,
    input  logic [1:0]                 random_seed,
    input  logic                       high_trigger,
    input  logic                       retrans_trigger,
    input  logic                       quit_retrans,
    input  logic                       tx_bb_is_ongoing,
    input  logic                       ack_tx_flag,
    output logic                       backoff_done,
    output csma_timing_pkg::slot_cnt_t num_slot_random_log_dl,
    output csma_timing_pkg::cw_exp_t   cw_exp_log_dl
);

    rx_frame_if frame_if ();

    logic                       medium_idle;  // channel idle and nav expired
    logic                       take_new;
    csma_timing_pkg::slot_cnt_t num_slot;

    assign frame_if.header_valid_strobe = pkt_header_valid_strobe;
    assign frame_if.header_valid        = pkt_header_valid;
    assign frame_if.fc_valid            = fc_di_valid;
    assign frame_if.fc_type             = fc_type;
    assign frame_if.fc_subtype          = fc_subtype;
    assign frame_if.duration            = duration;
    assign frame_if.addr1_valid         = addr1_valid;
    assign frame_if.addr1               = addr1;
    assign frame_if.fcs_strobe          = fcs_in_strobe;
    assign frame_if.fcs_valid           = fcs_valid;

    nav_tracker nav_tracker_i (
        .clk           (clk),
        .rstn          (rstn),
        .tsf_pulse_1M  (tsf_pulse_1M),
        .frame         (frame_if),
        .self_mac_addr (self_mac_addr),
        .nav_enable    (nav_enable),
        .ch_idle       (ch_idle),
        .medium_idle   (medium_idle)
    );

    slot_draw slot_draw_i (
        .clk         (clk),
        .rstn        (rstn),
        .take_new    (take_new),
        .cw_exp      (cw_exp_used),
        .random_seed (random_seed),
        .num_slot    (num_slot)
    );

    backoff_fsm backoff_fsm_i (
        .clk                    (clk),
        .rstn                   (rstn),
        .tsf_pulse_1M           (tsf_pulse_1M),
        .medium_idle            (medium_idle),
        .fcs_strobe             (frame_if.fcs_strobe),
        .fcs_valid              (frame_if.fcs_valid),
        .difs_enable            (difs_enable),
        .eifs_enable            (eifs_enable),
        .slot_time              (slot_time),
        .sifs_time              (sifs_time),
        .difs_advance           (difs_advance),
        .backoff_advance        (backoff_advance),
        .cw_exp_used            (cw_exp_used),
        .num_slot               (num_slot),
        .high_trigger           (high_trigger),
        .retrans_trigger        (retrans_trigger),
        .quit_retrans           (quit_retrans),
        .tx_bb_is_ongoing       (tx_bb_is_ongoing),
        .ack_tx_flag            (ack_tx_flag),
        .take_new               (take_new),
        .backoff_done           (backoff_done),
        .num_slot_random_log_dl (num_slot_random_log_dl),
        .cw_exp_log_dl          (cw_exp_log_dl)
    );

endmodule

// File: sim/csma_ref.svh
// Access timing reference model
`ifndef CSMA_REF_SVH
`define CSMA_REF_SVH

// ticks from a request to the end of the interframe wait
function automatic int ref_ifs_wait(input bit difs_en, input bit eifs_en, input bit fcs_good,
                                    input int slot, input int sifs, input int advance);
    int difs;
    int eifs;
    int ifs;
    difs = difs_en ? sifs + 2 * slot : 0;
    eifs = eifs_en ? sifs + difs + int'(csma_timing_pkg::LONGEST_ACK_TIME) : 0;
    ifs  = fcs_good ? difs : eifs;  // eifs after a bad fcs
    return (ifs == 0) ? 0 : ifs - advance;
endfunction

// shift left, feedback is xnor of bits 31, 21, 1 and 0
function automatic logic [31:0] ref_lfsr_step(input logic [31:0] lfsr);
    logic fb;
    fb = !(lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]);
    return {lfsr[30:0], fb};
endfunction

function automatic int ref_slot_draw(input logic [31:0] lfsr, input int cw, input logic [1:0] seed);
    int         e;
    logic [9:0] slots;
    e     = (cw > int'(csma_timing_pkg::CW_EXP_MAX)) ? int'(csma_timing_pkg::CW_EXP_MAX) : cw;
    slots = '0;
    for (int i = 0; i < e; i++) begin
        slots[i] = lfsr[i];
    end
    if (e >= 1) slots[0] = slots[0] ^ seed[1];
    if (e >= 2) slots[1] = slots[1] ^ seed[0];
    return int'(slots);
endfunction

// slot backoff in ticks, none without slots
function automatic int ref_backoff_ticks(input int slots, input int slot, input int advance);
    if (slots == 0) return 0;
    return slots * slot - advance;
endfunction

`endif

// File: sim/tb_csma_ca.sv
// CSMA/CA controller testbench
module tb_csma_ca;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLOT_TIME       = 9;
    localparam int SIFS_TIME       = 16;
    localparam int DIFS_ADVANCE    = 2;
    localparam int BACKOFF_ADVANCE = 0;
    localparam int NUM_RETRANS     = 4;
    localparam int BUSY_TICKS      = 20;
    localparam int MAX_WAIT_TICKS  = 8191 + 400;  // full backoff timer plus eifs and nav
    localparam int TIMEOUT_CYCLES  = (NUM_RETRANS + 3) * MAX_WAIT_TICKS * 4 + 2000;
    localparam mac_frame_pkg::mac_addr_t SELF_ADDR = 48'h0200_0000_0001;
    localparam mac_frame_pkg::mac_addr_t PEER_ADDR = 48'h0200_0000_007e;

    logic                       clk = 1'b0;
    logic                       rstn;
    logic                       tsf_pulse_1M;
    logic                       pkt_header_valid;
    logic                       pkt_header_valid_strobe;
    logic                       fc_di_valid;
    mac_frame_pkg::fc_type_t    fc_type;
    mac_frame_pkg::fc_subtype_t fc_subtype;
    mac_frame_pkg::duration_t   duration;
    logic                       addr1_valid;
    mac_frame_pkg::mac_addr_t   addr1;
    mac_frame_pkg::mac_addr_t   self_mac_addr;
    logic                       fcs_in_strobe;
    logic                       fcs_valid;
    logic                       nav_enable;
    logic                       ch_idle;
    logic                       difs_enable;
    logic                       eifs_enable;
    csma_timing_pkg::cw_exp_t   cw_exp_used;
    csma_timing_pkg::usec_t     slot_time;
    csma_timing_pkg::usec_t     sifs_time;
    csma_timing_pkg::usec_t     difs_advance;
    csma_timing_pkg::usec_t     backoff_advance;
    logic [1:0]                 random_seed;
    logic                       high_trigger;
    logic                       retrans_trigger;
    logic                       quit_retrans;
    logic                       tx_bb_is_ongoing;
    logic                       ack_tx_flag;
    logic                       backoff_done;
    csma_timing_pkg::slot_cnt_t num_slot_random_log_dl;
    csma_timing_pkg::cw_exp_t   cw_exp_log_dl;

    logic [1:0]  tick_phase = '0;
    int          tick_count = 0;   // 1 us ticks seen by the dut
    int          cycle_count = 0;
    int          seed = 15;
    logic [31:0] lfsr_model = csma_timing_pkg::LFSR_RESET_VALUE;
    bit          last_fcs_good = 1'b0;
    bit          armed = 1'b0;     // an expected backoff_done is pending
    int          start_tick;
    int          exp_lo;
    int          exp_hi;
    bit          exp_logs;
    int          exp_slot;
    int          exp_cw;
    string       test_name;

    `include "csma_ref.svh"

    csma_ca csma_ca_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        #1;
        tsf_pulse_1M = (tick_phase == 2'd3);  // one tick every 4th cycle
        tick_phase   = tick_phase + 2'd1;
    end

    always @(posedge clk) begin
        if (tsf_pulse_1M) tick_count <= tick_count + 1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail: time %0d ns, %s (got %0d, expected %0d)",
                     $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_request(input bit retrans);
        next_cycle();
        high_trigger    = !retrans;
        retrans_trigger = retrans;
        next_cycle();
        high_trigger    = 1'b0;
        retrans_trigger = 1'b0;
        start_tick      = tick_count;  // ticks counted after the sampling edge
    endtask

    task automatic expect_done(input string name, input int lo, input int hi, input bit logs,
                               input int slot, input int cw);
        test_name = name;
        exp_lo    = lo;
        exp_hi    = hi;
        exp_logs  = logs;
        exp_slot  = slot;
        exp_cw    = cw;
        armed     = 1'b1;
        wait (!armed);
    endtask

    task automatic end_transmit(input bit ack, input bit busy);
        next_cycle();
        tx_bb_is_ongoing = 1'b1;
        ack_tx_flag      = ack;
        ch_idle          = !busy;
        next_cycle();
        tx_bb_is_ongoing = 1'b0;
        ack_tx_flag      = 1'b0;
        check_equal(backoff_done, 0, "backoff_done not cleared by transmit start");
    endtask

    task automatic fcs_event(input bit good);
        next_cycle();
        fcs_in_strobe = 1'b1;
        fcs_valid     = good;
        next_cycle();
        fcs_in_strobe = 1'b0;
        last_fcs_good = good;
    endtask

    task automatic send_frame(input mac_frame_pkg::mac_addr_t dest, input int dur);
        next_cycle();
        pkt_header_valid_strobe = 1'b1;
        next_cycle();
        pkt_header_valid_strobe = 1'b0;
        fc_di_valid             = 1'b1;
        duration                = mac_frame_pkg::duration_t'(dur);
        next_cycle();
        fc_di_valid = 1'b0;
        addr1_valid = 1'b1;
        addr1       = dest;
        next_cycle();
        fcs_event(1'b1);
        addr1_valid = 1'b0;
        repeat (2) next_cycle();  // nav loads after the fcs
    endtask

    task automatic predict_backoff(input int cw, output int slots, output int bo);
        lfsr_model = ref_lfsr_step(lfsr_model);  // one draw per retransmission wait
        slots      = ref_slot_draw(lfsr_model, cw, random_seed);
        bo         = ref_backoff_ticks(slots, SLOT_TIME, BACKOFF_ADVANCE);
    endtask

    initial begin : compare
        int elapsed;
        forever begin
            @(negedge clk);
            if (armed && backoff_done === 1'b1) begin
                elapsed = tick_count - start_tick;
                check_equal(elapsed >= exp_lo, 1, $sformatf("%s: done after %0d ticks, min %0d",
                            test_name, elapsed, exp_lo));
                check_equal(elapsed <= exp_hi, 1, $sformatf("%s: done after %0d ticks, max %0d",
                            test_name, elapsed, exp_hi));
                repeat (3) @(negedge clk);  // logs trail by two cycles
                if (exp_logs) begin
                    check_equal(num_slot_random_log_dl, exp_slot, {test_name, ": slot log"});
                    check_equal(cw_exp_log_dl, exp_cw, {test_name, ": exponent log"});
                end
                armed = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int ifs;
        int eifs;
        int dur;
        int cw;
        int slots;
        int bo;
        int best;
        rstn = 1'b0;
        tsf_pulse_1M = 1'b0;
        pkt_header_valid = 1'b1;
        pkt_header_valid_strobe = 1'b0;
        fc_di_valid = 1'b0;
        fc_type = 2'b10;
        fc_subtype = 4'd0;
        duration = '0;
        addr1_valid = 1'b0;
        addr1 = '0;
        self_mac_addr = SELF_ADDR;
        fcs_in_strobe = 1'b0;
        fcs_valid = 1'b0;
        nav_enable = 1'b1;
        ch_idle = 1'b1;
        difs_enable = 1'b1;
        eifs_enable = 1'b1;
        cw_exp_used = '0;
        slot_time = SLOT_TIME;
        sifs_time = SIFS_TIME;
        difs_advance = DIFS_ADVANCE;
        backoff_advance = BACKOFF_ADVANCE;
        random_seed = 2'b11;
        high_trigger = 1'b0;
        retrans_trigger = 1'b0;
        quit_retrans = 1'b0;
        tx_bb_is_ongoing = 1'b0;
        ack_tx_flag = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        next_cycle();
        check_equal(backoff_done, 0, "backoff_done after reset");
        check_equal(num_slot_random_log_dl, 0, "slot log after reset");
        check_equal(cw_exp_log_dl, 0, "exponent log after reset");

        // new frame after good and bad fcs
        fcs_event(1'b1);
        ifs = ref_ifs_wait(difs_enable, eifs_enable, last_fcs_good, SLOT_TIME, SIFS_TIME,
                           DIFS_ADVANCE);
        issue_request(1'b0);
        expect_done("difs request", ifs, ifs + 1, 1'b1, 0, 0);
        end_transmit(1'b0, 1'b0);
        fcs_event(1'b0);
        eifs = ref_ifs_wait(difs_enable, eifs_enable, last_fcs_good, SLOT_TIME, SIFS_TIME,
                            DIFS_ADVANCE);
        issue_request(1'b0);
        expect_done("eifs request", eifs, eifs + 1, 1'b1, 0, 0);
        end_transmit(1'b0, 1'b0);

        // nav from a frame to another station, none from a frame to us
        dur = ifs + 8 + $unsigned($random(seed)) % 200;  // longer than a plain ifs wait
        cw_exp_used = '0;
        send_frame(PEER_ADDR, dur);
        issue_request(1'b0);
        predict_backoff(0, slots, bo);  // busy medium forces a backoff wait
        expect_done("nav to peer", dur, dur + ifs + 1, 1'b0, 0, 0);
        end_transmit(1'b0, 1'b0);
        send_frame(SELF_ADDR, dur);
        issue_request(1'b0);
        expect_done("nav to self", ifs, ifs + 1, 1'b1, 0, 0);
        end_transmit(1'b0, 1'b0);

        for (int n = 0; n < NUM_RETRANS; n++) begin
            cw = $unsigned($random(seed)) % 11;
            cw_exp_used = cw;
            predict_backoff(cw, slots, bo);
            issue_request(1'b1);
            expect_done("retransmission", ifs + bo, ifs + bo + 1, 1'b1, slots, cw);
            end_transmit(1'b0, 1'b0);
        end

        // suspend and resume, seed picked for a backoff of at least 3 slots
        best = 0;
        for (int s = 0; s < 4; s++) begin
            if (ref_slot_draw(ref_lfsr_step(lfsr_model), 4, s) >
                ref_slot_draw(ref_lfsr_step(lfsr_model), 4, best)) best = s;
        end
        random_seed = best;
        cw_exp_used = 4'd4;
        predict_backoff(4, slots, bo);
        issue_request(1'b1);
        fork
            expect_done("suspend", ifs + bo + BUSY_TICKS, ifs + bo + BUSY_TICKS + 2, 1'b1,
                        slots, 4);
            begin
                while (tick_count - start_tick < ifs + 4) next_cycle();
                ch_idle = 1'b0;
                dur = tick_count;
                while (tick_count - dur < BUSY_TICKS) next_cycle();
                check_equal(backoff_done, 0, "backoff_done while medium busy");
                check_equal(num_slot_random_log_dl, slots, "slot log while suspended");
                ch_idle = 1'b1;
            end
        join
        end_transmit(1'b0, 1'b0);

        // own ack leaves the medium busy, then a fresh ifs and backoff
        issue_request(1'b0);
        expect_done("before ack", ifs, ifs + 1, 1'b1, 0, 0);
        end_transmit(1'b1, 1'b1);
        repeat (BUSY_TICKS * 4) next_cycle();
        check_equal(backoff_done, 0, "backoff_done during own transmission");
        cw = $unsigned($random(seed)) % 11;
        cw_exp_used = cw;
        predict_backoff(cw, slots, bo);
        ch_idle = 1'b1;
        next_cycle();
        start_tick = tick_count;
        expect_done("after ack", ifs + bo, ifs + bo + 1, 1'b1, slots, cw);
        end_transmit(1'b0, 1'b0);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+sim
common/csma_timing_pkg.sv
common/mac_frame_pkg.sv
common/rx_frame_if.sv
rtl/nav/nav_tracker.sv
rtl/backoff/slot_draw.sv
rtl/backoff/backoff_fsm.sv
rtl/csma_ca.sv
sim/tb_csma_ca.sv

// File: Bender.yml
package:
  name: csma_ca

sources:
  - common/csma_timing_pkg.sv
  - common/mac_frame_pkg.sv
  - common/rx_frame_if.sv
  - rtl/nav/nav_tracker.sv
  - rtl/backoff/slot_draw.sv
  - rtl/backoff/backoff_fsm.sv
  - rtl/csma_ca.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_csma_ca.sv
